/* logic/cfi_snoop_pkg.sv */
package cfi_snoop_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  localparam int unsigned NumCores       = 2;
  localparam int unsigned PcWidth        = 64;
  localparam int unsigned WordWidth      = 32;
  localparam int unsigned MetaWidth      = 4;
  localparam int unsigned FifoDepth      = 8;
  localparam int unsigned FifoAddrWidth  = 3;
  localparam int unsigned WordsPerEntry  = 6;

  // Fill level that raises the interrupt
  localparam int unsigned WatermarkLevel = 6;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------
  typedef logic [PcWidth-1:0]   pc_t;
  typedef logic [WordWidth-1:0] word_t;
  typedef logic [MetaWidth-1:0] meta_t;
  typedef logic [1:0]           priv_t;

  // Word 0 sits in the low bits
  typedef word_t [WordsPerEntry-1:0] entry_t;

  // Holds 0 up to FifoDepth
  typedef logic [FifoAddrWidth:0] level_t;

  typedef logic [15:0] drop_cnt_t;

  typedef enum logic [0:0] {
    READ_IDLE,
    READ_SEND
  } readout_state_e;

endpackage

/* logic/trace_capture.sv */
`timescale 1ns/10ps

module trace_capture (
  input  logic                                       clk_i,
  input  logic                                       ndmreset_n,
  input  logic                                       core_sel_i,
  input  logic [cfi_snoop_pkg::NumCores-1:0]         trace_valid_i,
  input  cfi_snoop_pkg::pc_t                         pc_src_i [cfi_snoop_pkg::NumCores],
  input  cfi_snoop_pkg::pc_t                         pc_dst_i [cfi_snoop_pkg::NumCores],
  input  cfi_snoop_pkg::meta_t                       meta_i [cfi_snoop_pkg::NumCores],
  input  cfi_snoop_pkg::priv_t                       priv_i [cfi_snoop_pkg::NumCores],
  input  cfi_snoop_pkg::word_t                       instr_i [cfi_snoop_pkg::NumCores],
  input  logic                                       fifo_full_i,
  output logic                                       push_o,
  output cfi_snoop_pkg::entry_t                      push_entry_o,
  output cfi_snoop_pkg::drop_cnt_t                   drop_cnt_o
);
  import cfi_snoop_pkg::*;

  logic      sel_valid;
  entry_t    sel_entry;
  logic      valid_q;
  entry_t    entry_q;
  drop_cnt_t drop_cnt_q;

  // PC bits 62..32 under a zero top bit
  function automatic word_t pc_high(pc_t pc);
    return {1'b0, pc[PcWidth-2:WordWidth]};
  endfunction

  // PC bits 31..1, bit 0 forced to zero
  function automatic word_t pc_low(pc_t pc);
    return {pc[WordWidth-1:1], 1'b0};
  endfunction

  // ----------------------------------------------------------
  // Core select and packing
  // ----------------------------------------------------------
  always_comb begin
    sel_valid    = trace_valid_i[core_sel_i];
    sel_entry[0] = pc_high(pc_src_i[core_sel_i]);
    sel_entry[1] = pc_low(pc_src_i[core_sel_i]);
    sel_entry[2] = pc_high(pc_dst_i[core_sel_i]);
    sel_entry[3] = pc_low(pc_dst_i[core_sel_i]);
    sel_entry[4] = {{(WordWidth - MetaWidth - 2){1'b0}},
                    priv_i[core_sel_i], meta_i[core_sel_i]};
    sel_entry[5] = instr_i[core_sel_i];
  end

  // ----------------------------------------------------------
  // Capture register
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sel_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_valid) begin
      entry_q <= sel_entry;
    end
  end

  // Captured entry goes into the buffer unless it is full
  assign push_o       = valid_q & ~fifo_full_i;
  assign push_entry_o = entry_q;

  // Lost entries, saturating
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      drop_cnt_q <= '0;
    end else if (valid_q && fifo_full_i && (drop_cnt_q != '1)) begin
      drop_cnt_q <= drop_cnt_q + 1'b1;
    end
  end

  assign drop_cnt_o = drop_cnt_q;

  a_push_known: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    !$isunknown(push_o)
  );

endmodule

/* logic/trace_fifo.sv */
`timescale 1ns/10ps

module trace_fifo (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  push_i,
  input  cfi_snoop_pkg::entry_t push_entry_i,
  input  logic                  pop_i,
  output cfi_snoop_pkg::entry_t pop_entry_o,
  output logic                  full_o,
  output logic                  empty_o,
  output cfi_snoop_pkg::level_t level_o
);
  import cfi_snoop_pkg::*;

  entry_t                   mem_q [FifoDepth];
  logic [FifoAddrWidth-1:0] wptr_q;
  logic [FifoAddrWidth-1:0] rptr_q;
  level_t                   count_q;

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wptr_q] <= push_entry_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop_i) begin
        rptr_q <= rptr_q + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      count_q <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign pop_entry_o = mem_q[rptr_q];
  assign full_o      = (count_q == level_t'(FifoDepth));
  assign empty_o     = (count_q == '0);
  assign level_o     = count_q;

  // Capture must hold back when full, readout must wait for data
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    push_i |-> !full_o
  );

  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    pop_i |-> !empty_o
  );

endmodule

/* logic/trace_readout.sv */
`timescale 1ns/10ps

module trace_readout (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  fifo_empty_i,
  input  cfi_snoop_pkg::level_t fifo_level_i,
  input  cfi_snoop_pkg::entry_t pop_entry_i,
  output logic                  pop_o,
  output cfi_snoop_pkg::word_t  word_o,
  output logic                  word_valid_o,
  output logic                  word_last_o,
  output logic                  watermark_irq_o
);
  import cfi_snoop_pkg::*;

  typedef logic [$clog2(WordsPerEntry)-1:0] word_idx_t;

  readout_state_e state_q;
  readout_state_e state_d;
  word_idx_t      word_cnt_q;
  entry_t         entry_q;
  logic           last_word;
  logic           irq_q;

  // ----------------------------------------------------------
  // Readout FSM
  // ----------------------------------------------------------
  assign last_word = (word_cnt_q == word_idx_t'(WordsPerEntry - 1));

  // One pop per entry and only while idle
  assign pop_o = (state_q == READ_IDLE) & ~fifo_empty_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      READ_IDLE: begin
        if (pop_o) begin
          state_d = READ_SEND;
        end
      end
      READ_SEND: begin
        if (last_word) begin
          state_d = READ_IDLE;
        end
      end
      default: state_d = READ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q    <= READ_IDLE;
      word_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (pop_o || last_word) begin
        word_cnt_q <= '0;
      end else if (state_q == READ_SEND) begin
        word_cnt_q <= word_cnt_q + 1'b1;
      end
    end
  end

  // Head entry is latched on the pop edge
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      entry_q <= pop_entry_i;
    end
  end

  assign word_o       = entry_q[word_cnt_q];
  assign word_valid_o = (state_q == READ_SEND);
  assign word_last_o  = word_valid_o & last_word;

  // ----------------------------------------------------------
  // Watermark
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= (fifo_level_i >= level_t'(WatermarkLevel));
    end
  end

  assign watermark_irq_o = irq_q;

  // Last word closes the burst that its pop started
  a_last_in_burst: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    word_last_o |-> word_valid_o && $past(pop_o, WordsPerEntry)
  );

  // Every pop yields exactly one burst of six words
  a_burst_length: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    pop_o |=> word_valid_o [*WordsPerEntry] ##1 !word_valid_o
  );

endmodule

/* logic/cfi_snoop_top.sv */
`timescale 1ns/10ps

module cfi_snoop_top (
  input  logic                               clk_i,
  input  logic                               ndmreset_n,
  // Per core trace
  input  logic [cfi_snoop_pkg::NumCores-1:0] trace_valid_i,
  input  cfi_snoop_pkg::pc_t                 pc_src_i [cfi_snoop_pkg::NumCores],
  input  cfi_snoop_pkg::pc_t                 pc_dst_i [cfi_snoop_pkg::NumCores],
  input  cfi_snoop_pkg::meta_t               meta_i [cfi_snoop_pkg::NumCores],
  input  cfi_snoop_pkg::priv_t               priv_i [cfi_snoop_pkg::NumCores],
  input  cfi_snoop_pkg::word_t               instr_i [cfi_snoop_pkg::NumCores],
  input  logic                               core_sel_i,
  // Readout
  output cfi_snoop_pkg::word_t               word_o,
  output logic                               word_valid_o,
  output logic                               word_last_o,
  output logic                               watermark_irq_o,
  output cfi_snoop_pkg::drop_cnt_t           drop_cnt_o
);
  import cfi_snoop_pkg::*;

  logic   push;
  entry_t push_entry;
  logic   pop;
  entry_t pop_entry;
  logic   fifo_full;
  logic   fifo_empty;
  level_t fifo_level;

  // ----------------------------------------------------------
  // Capture, buffer, readout
  // ----------------------------------------------------------
  trace_capture i_trace_capture (
    .clk_i         ( clk_i         ),
    .ndmreset_n    ( ndmreset_n    ),
    .core_sel_i    ( core_sel_i    ),
    .trace_valid_i ( trace_valid_i ),
    .pc_src_i      ( pc_src_i      ),
    .pc_dst_i      ( pc_dst_i      ),
    .meta_i        ( meta_i        ),
    .priv_i        ( priv_i        ),
    .instr_i       ( instr_i       ),
    .fifo_full_i   ( fifo_full     ),
    .push_o        ( push          ),
    .push_entry_o  ( push_entry    ),
    .drop_cnt_o    ( drop_cnt_o    )
  );

  trace_fifo i_trace_fifo (
    .clk_i        ( clk_i      ),
    .ndmreset_n   ( ndmreset_n ),
    .push_i       ( push       ),
    .push_entry_i ( push_entry ),
    .pop_i        ( pop        ),
    .pop_entry_o  ( pop_entry  ),
    .full_o       ( fifo_full  ),
    .empty_o      ( fifo_empty ),
    .level_o      ( fifo_level )
  );

  trace_readout i_trace_readout (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .fifo_empty_i    ( fifo_empty      ),
    .fifo_level_i    ( fifo_level      ),
    .pop_entry_i     ( pop_entry       ),
    .pop_o           ( pop             ),
    .word_o          ( word_o          ),
    .word_valid_o    ( word_valid_o    ),
    .word_last_o     ( word_last_o     ),
    .watermark_irq_o ( watermark_irq_o )
  );

endmodule

/* testbench/tb_cfi_snoop.sv */
`timescale 1ns/10ps

module tb_cfi_snoop;
  import cfi_snoop_pkg::*;

  logic                clk_i;
  logic                ndmreset_n;
  logic                core_sel;
  logic [NumCores-1:0] trace_valid;
  pc_t                 pc_src [NumCores];
  pc_t                 pc_dst [NumCores];
  meta_t               meta [NumCores];
  priv_t               priv [NumCores];
  word_t               instr [NumCores];
  word_t               word;
  logic                word_valid;
  logic                word_last;
  logic                watermark_irq;
  drop_cnt_t           drop_cnt;

  logic [31:0] lfsr_q;
  int          value_errors;
  int          other_errors;
  int          sent_cnt;
  int          last_cnt;
  logic        irq_seen;

  // Reference model of capture, buffer and readout
  entry_t         model_q [$];
  entry_t         m_entry_q;
  logic           m_valid_q;
  readout_state_e m_state;
  logic [2:0]     m_cnt;
  entry_t         m_cur;
  logic           m_irq;
  drop_cnt_t      m_drops;
  logic           exp_valid;
  logic           exp_last;
  word_t          exp_word;

  always #10 clk_i = ~clk_i;

  cfi_snoop_top dut (
    .clk_i           ( clk_i         ),
    .ndmreset_n      ( ndmreset_n    ),
    .trace_valid_i   ( trace_valid   ),
    .pc_src_i        ( pc_src        ),
    .pc_dst_i        ( pc_dst        ),
    .meta_i          ( meta          ),
    .priv_i          ( priv          ),
    .instr_i         ( instr         ),
    .core_sel_i      ( core_sel      ),
    .word_o          ( word          ),
    .word_valid_o    ( word_valid    ),
    .word_last_o     ( word_last     ),
    .watermark_irq_o ( watermark_irq ),
    .drop_cnt_o      ( drop_cnt      )
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[62:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic entry_t pack_trace(input logic sel);
    entry_t e;
    e[0] = {1'b0, pc_src[sel][62:32]};
    e[1] = {pc_src[sel][31:1], 1'b0};
    e[2] = {1'b0, pc_dst[sel][62:32]};
    e[3] = {pc_dst[sel][31:1], 1'b0};
    e[4] = {26'd0, priv[sel], meta[sel]};
    e[5] = instr[sel];
    return e;
  endfunction

  task automatic flag_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    value_errors++;
    $display("[ERROR] %0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
    if (word_last) last_cnt++;
    if (watermark_irq) irq_seen = 1'b1;
  endtask

  // New fields on both cores every cycle, other core's valid is noise
  task automatic drive_cycle(input logic sel_valid);
    for (int c = 0; c < NumCores; c++) begin
      pc_src[c] = random_bits(64);
      pc_dst[c] = random_bits(64);
      meta[c]   = meta_t'(random_bits(MetaWidth));
      priv[c]   = priv_t'(random_bits(2));
      instr[c]  = word_t'(random_bits(WordWidth));
    end
    trace_valid[core_sel]  = sel_valid;
    trace_valid[~core_sel] = 1'(random_bits(1));
    if (sel_valid) sent_cnt++;
    step();
  endtask

  function automatic logic busy();
    return (model_q.size() != 0) || m_valid_q || (m_state != READ_IDLE) || word_valid;
  endfunction

  task automatic wait_drained();
    int n;
    n = 0;
    while (busy() && n < 300) begin
      drive_cycle(1'b0);
      n++;
    end
    if (busy()) begin
      other_errors++;
      $display("Timeout at %0t: trace buffer did not drain", $time);
    end
  endtask

  task automatic check_latency();
    int lat;
    drive_cycle(1'b1);
    lat = 1;
    while (!word_valid && lat < 20) begin
      drive_cycle(1'b0);
      lat++;
    end
    if (!word_valid) begin
      other_errors++;
      $display("Timeout at %0t: no readout word after a trace valid", $time);
    end else if (lat != 3) begin
      flag_mismatch("first word latency", 3, lat);
    end
  endtask

  task automatic send_sparse(input int n);
    int gap;
    repeat (n) begin
      drive_cycle(1'b1);
      gap = 7 + int'(random_bits(3));
      repeat (gap) drive_cycle(1'b0);
    end
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  always @(posedge clk_i or negedge ndmreset_n) begin : ref_model
    logic sel_valid;
    logic full;
    if (!ndmreset_n) begin
      model_q.delete();
      m_valid_q <= 1'b0;
      m_state   <= READ_IDLE;
      m_cnt     <= '0;
      m_irq     <= 1'b0;
      m_drops   <= '0;
    end else begin
      sel_valid = trace_valid[core_sel];
      full      = (model_q.size() == FifoDepth);
      m_irq     <= (model_q.size() >= WatermarkLevel);
      if (m_valid_q && full && m_drops != '1) m_drops <= m_drops + 1'b1;
      if (sel_valid) m_entry_q <= pack_trace(core_sel);
      m_valid_q <= sel_valid;
      if (m_state == READ_IDLE) begin
        if (model_q.size() != 0) begin
          m_cur   <= model_q.pop_front();
          m_state <= READ_SEND;
          m_cnt   <= '0;
        end
      end else if (m_cnt == 3'(WordsPerEntry - 1)) begin
        m_state <= READ_IDLE;
        m_cnt   <= '0;
      end else begin
        m_cnt <= m_cnt + 1'b1;
      end
      // Pop above sees the head before this edge's push
      if (m_valid_q && !full) model_q.push_back(m_entry_q);
    end
  end

  assign exp_valid = (m_state == READ_SEND);
  assign exp_last  = exp_valid && (m_cnt == 3'(WordsPerEntry - 1));
  assign exp_word  = m_cur[m_cnt];

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_reset_quiet: assert property (@(posedge clk_i)
    !ndmreset_n |-> (!word_valid && !word_last && !watermark_irq && drop_cnt == '0))
    else begin
      other_errors++;
      $display("Outputs not idle during reset at %0t", $time);
    end

  a_word_valid: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    word_valid == exp_valid)
    else flag_mismatch("word_valid_o", $sampled(exp_valid), $sampled(word_valid));

  a_word_last: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    word_last == exp_last)
    else flag_mismatch("word_last_o", $sampled(exp_last), $sampled(word_last));

  a_word: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    exp_valid |-> word == exp_word)
    else flag_mismatch("word_o", $sampled(exp_word), $sampled(word));

  a_irq: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    watermark_irq == m_irq)
    else flag_mismatch("watermark_irq_o", $sampled(m_irq), $sampled(watermark_irq));

  a_drop_cnt: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    drop_cnt == m_drops)
    else flag_mismatch("drop_cnt_o", $sampled(m_drops), $sampled(drop_cnt));

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    int sent0;
    int last0;
    int drop0;
    clk_i       = 1'b0;
    ndmreset_n  = 1'b1;
    core_sel    = 1'b0;
    trace_valid = '0;
    for (int c = 0; c < NumCores; c++) begin
      pc_src[c] = '0;
      pc_dst[c] = '0;
      meta[c]   = '0;
      priv[c]   = '0;
      instr[c]  = '0;
    end
    lfsr_q       = 32'd89808;
    value_errors = 0;
    other_errors = 0;
    sent_cnt     = 0;
    last_cnt     = 0;
    irq_seen     = 1'b0;
    #1;
    ndmreset_n = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    ndmreset_n = 1'b1;

    // Single traces from core 0 into an empty buffer
    repeat (4) begin
      wait_drained();
      check_latency();
    end
    wait_drained();

    // Core 1 selected, core 0 traffic ignored
    core_sel = 1'b1;
    sent0    = sent_cnt;
    last0    = last_cnt;
    send_sparse(6);
    wait_drained();
    if (last_cnt - last0 != sent_cnt - sent0) begin
      flag_mismatch("entries out", sent_cnt - sent0, last_cnt - last0);
    end

    // Random traces slower than the readout
    core_sel = 1'b0;
    sent0    = sent_cnt;
    last0    = last_cnt;
    send_sparse(12);
    wait_drained();
    if (last_cnt - last0 != sent_cnt - sent0) begin
      flag_mismatch("entries out", sent_cnt - sent0, last_cnt - last0);
    end
    if (drop_cnt != '0) flag_mismatch("drop_cnt_o", 0, drop_cnt);

    // Back to back burst overflows the buffer
    sent0    = sent_cnt;
    last0    = last_cnt;
    drop0    = drop_cnt;
    irq_seen = 1'b0;
    repeat (24) drive_cycle(1'b1);
    wait_drained();
    if (drop_cnt == drop0) begin
      other_errors++;
      $display("Burst did not overflow the trace buffer");
    end
    if (last_cnt - last0 != (sent_cnt - sent0) - (drop_cnt - drop0)) begin
      flag_mismatch("entries out", (sent_cnt - sent0) - (drop_cnt - drop0), last_cnt - last0);
    end
    if (!irq_seen) begin
      other_errors++;
      $display("Watermark interrupt never rose during the burst");
    end
    if (watermark_irq) begin
      other_errors++;
      $display("Watermark interrupt still high after the buffer drained");
    end

    repeat (4) drive_cycle(1'b0);
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* cfi_snoop.f */
logic/cfi_snoop_pkg.sv
logic/trace_capture.sv
logic/trace_fifo.sv
logic/trace_readout.sv
logic/cfi_snoop_top.sv
testbench/tb_cfi_snoop.sv

/* Bender.yml */
package:
  name: cfi_snoop

sources:
  - logic/cfi_snoop_pkg.sv
  - logic/trace_capture.sv
  - logic/trace_fifo.sv
  - logic/trace_readout.sv
  - logic/cfi_snoop_top.sv
  - target: test
    files:
      - testbench/tb_cfi_snoop.sv
